// ==== verilog/rvCorePkg.sv ====
package rvCorePkg;

    parameter int XLEN = 32;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'b0000,
        ALU_SLL  = 4'b0001,
        ALU_SLT  = 4'b0010,
        ALU_SLTU = 4'b0011,
        ALU_XOR  = 4'b0100,
        ALU_SRL  = 4'b0101,
        ALU_OR   = 4'b0110,
        ALU_AND  = 4'b0111,
        ALU_SUB  = 4'b1000,
        ALU_SRA  = 4'b1101
    } aluOpE; // {funct7[5], funct3}

    typedef enum logic [1:0] {RES_ALU, RES_MEM, RES_PCPLUS4, RES_IMM} resultSrcE;

    typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_J, IMM_U} immSrcE;

    typedef enum logic [2:0] {
        MEM_WORD  = 3'b000,
        MEM_HALF  = 3'b001,
        MEM_BYTE  = 3'b010,
        MEM_HALFU = 3'b101,
        MEM_BYTEU = 3'b110
    } memWidthE; // bit 2 set for unsigned loads

    typedef struct packed {
        logic      regWrite;
        logic      memWrite;
        logic      pcSrc;
        logic      jalr;
        logic      aluSrc;
        resultSrcE resultSrc;
        immSrcE    immSrc;
        aluOpE     aluCtrl;
        memWidthE  dataWidth;
    } ctrlSignalsT;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] instr;
    } fetchPacketT;

    typedef struct packed {
        logic            taken;
        logic [XLEN-1:0] target;
    } redirectT;

endpackage

// ==== verilog/fetchStage.sv ====
module fetchStage
    import rvCorePkg::*;
#(
    parameter logic [XLEN-1:0] RESET_PC = '0
)
(
    input  logic            clk,
    input  logic            rstN,
    output logic [XLEN-1:0] instrAddr,
    input  logic [XLEN-1:0] instr,
    input  redirectT        redirect,
    output fetchPacketT     fetchPacket
);

    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] nextPc;

    assign instrAddr = pc;

    // a taken redirect wins over sequential fetch
    always_comb
    begin
        if (redirect.taken)
            nextPc = redirect.target;
        else
            nextPc = pc + 32'd4;
    end

    always_ff @(posedge clk)
    begin
        if (!rstN)
            pc <= RESET_PC;
        else
            pc <= nextPc;
    end

    // valid bit of the pipeline register, cleared on flush
    always_ff @(posedge clk)
    begin
        if (!rstN)
            fetchPacket.valid <= 1'b0;
        else
            fetchPacket.valid <= ~redirect.taken; // drop the word behind a redirect
    end

    always_ff @(posedge clk)
    begin
        fetchPacket.pc    <= pc;
        fetchPacket.instr <= instr;
    end

endmodule

// ==== verilog/controlUnit.sv ====
module controlUnit
    import rvCorePkg::*;
(
    input  logic [XLEN-1:0] instr,
    input  logic            zero,
    output ctrlSignalsT     ctrl
);

    localparam logic [6:0] OP_RTYPE = 7'b0110011;
    localparam logic [6:0] OP_ITYPE = 7'b0010011;
    localparam logic [6:0] OP_LOAD  = 7'b0000011;
    localparam logic [6:0] OP_STORE = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL   = 7'b1101111;
    localparam logic [6:0] OP_JALR  = 7'b1100111;
    localparam logic [6:0] OP_LUI   = 7'b0110111;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       funct7b5;

    assign opcode   = instr[6:0];
    assign funct3   = instr[14:12];
    assign funct7b5 = instr[30];

    always_comb
    begin
        ctrl = '0; // unknown opcodes fall through as a no-op
        ctrl.jalr = (opcode == OP_JALR);
        case (opcode)
            OP_RTYPE:
            begin
                ctrl.regWrite = 1'b1;
                ctrl.aluCtrl  = aluOpE'({funct7b5, funct3});
            end
            OP_ITYPE:
            begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.immSrc   = IMM_I;
                // only srai carries funct7 bit 5, it is part of the immediate otherwise
                ctrl.aluCtrl  = aluOpE'({(funct3 == 3'b101) & funct7b5, funct3});
            end
            OP_LOAD:
            begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrc    = 1'b1; // address is rs1 + imm
                ctrl.resultSrc = RES_MEM;
                ctrl.immSrc    = IMM_I;
                ctrl.aluCtrl   = ALU_ADD;
                case (funct3)
                    3'b000:  ctrl.dataWidth = MEM_BYTE;
                    3'b001:  ctrl.dataWidth = MEM_HALF;
                    3'b100:  ctrl.dataWidth = MEM_BYTEU;
                    3'b101:  ctrl.dataWidth = MEM_HALFU;
                    default: ctrl.dataWidth = MEM_WORD;
                endcase
            end
            OP_STORE:
            begin
                ctrl.memWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.immSrc   = IMM_S;
                ctrl.aluCtrl  = ALU_ADD;
                case (funct3)
                    3'b000:  ctrl.dataWidth = MEM_BYTE;
                    3'b001:  ctrl.dataWidth = MEM_HALF;
                    default: ctrl.dataWidth = MEM_WORD;
                endcase
            end
            OP_BRANCH:
            begin
                ctrl.immSrc  = IMM_B;
                ctrl.aluCtrl = ALU_SUB;
                // slt/sltu give a nonzero result when rs1 < rs2
                case (funct3)
                    3'b000: ctrl.pcSrc = zero; // beq
                    3'b001: ctrl.pcSrc = ~zero; // bne
                    3'b100:
                    begin
                        ctrl.aluCtrl = ALU_SLT;
                        ctrl.pcSrc   = ~zero; // blt
                    end
                    3'b101:
                    begin
                        ctrl.aluCtrl = ALU_SLT;
                        ctrl.pcSrc   = zero; // bge
                    end
                    3'b110:
                    begin
                        ctrl.aluCtrl = ALU_SLTU;
                        ctrl.pcSrc   = ~zero; // bltu
                    end
                    3'b111:
                    begin
                        ctrl.aluCtrl = ALU_SLTU;
                        ctrl.pcSrc   = zero; // bgeu
                    end
                    default: ctrl.pcSrc = 1'b0;
                endcase
            end
            OP_JAL:
            begin
                ctrl.regWrite  = 1'b1;
                ctrl.pcSrc     = 1'b1;
                ctrl.resultSrc = RES_PCPLUS4; // link value
                ctrl.immSrc    = IMM_J;
            end
            OP_JALR:
            begin
                ctrl.regWrite  = 1'b1;
                ctrl.pcSrc     = 1'b1;
                ctrl.aluSrc    = 1'b1; // alu forms rs1 + imm
                ctrl.resultSrc = RES_PCPLUS4;
                ctrl.immSrc    = IMM_I;
                ctrl.aluCtrl   = ALU_ADD;
            end
            OP_LUI:
            begin
                ctrl.regWrite  = 1'b1;
                ctrl.resultSrc = RES_IMM;
                ctrl.immSrc    = IMM_U;
            end
            default: ;
        endcase
    end

endmodule

// ==== verilog/aluUnit.sv ====
module aluUnit
    import rvCorePkg::*;
(
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    input  aluOpE           aluCtrl,
    output logic [XLEN-1:0] result,
    output logic            zero
);

    logic [4:0] shamt;

    assign shamt = b[4:0]; // rv32 shifts use 5 bits only

    always_comb
    begin
        case (aluCtrl)
            ALU_ADD:
                result = a + b;
            ALU_SUB:
                result = a - b;
            ALU_SLL:
                result = a << shamt;
            ALU_SLT:
                result = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            ALU_SLTU:
                result = {{(XLEN-1){1'b0}}, a < b};
            ALU_XOR:
                result = a ^ b;
            ALU_SRL:
                result = a >> shamt;
            ALU_SRA:
                result = $unsigned($signed(a) >>> shamt); // keeps sign bit
            ALU_OR:
                result = a | b;
            ALU_AND:
                result = a & b;
            default:
                result = '0;
        endcase
    end

    assign zero = (result == '0); // feeds the branch decision

endmodule

// ==== verilog/regFile.sv ====
module regFile
    import rvCorePkg::*;
(
    input  logic            clk,
    input  logic [4:0]      readAddr1,
    input  logic [4:0]      readAddr2,
    output logic [XLEN-1:0] readData1,
    output logic [XLEN-1:0] readData2,
    input  logic            writeEn,
    input  logic [4:0]      writeAddr,
    input  logic [XLEN-1:0] writeData
);

    logic [XLEN-1:0] regs [32];

    // x0 is hardwired, never stored
    always_ff @(posedge clk)
    begin
        if (writeEn && writeAddr != 5'd0)
            regs[writeAddr] <= writeData;
    end

    assign readData1 = (readAddr1 == 5'd0) ? '0 : regs[readAddr1];
    assign readData2 = (readAddr2 == 5'd0) ? '0 : regs[readAddr2];

endmodule

// ==== verilog/dataMemory.sv ====
module dataMemory
    import rvCorePkg::*;
#(
    parameter int DMEM_WORDS = 256
)
(
    input  logic            clk,
    input  logic [XLEN-1:0] addr,
    input  logic [XLEN-1:0] writeData,
    input  logic            memWrite,
    input  memWidthE        dataWidth,
    output logic [XLEN-1:0] readData
);

    localparam int ADDR_BITS = $clog2(DMEM_WORDS);

    logic [XLEN-1:0]      mem [DMEM_WORDS];
    logic [ADDR_BITS-1:0] wordIdx;
    logic [4:0]           laneShift;
    logic [XLEN-1:0]      laneData;

    assign wordIdx   = addr[ADDR_BITS+1:2]; // wraps modulo depth
    assign laneShift = {addr[1:0], 3'b000};

    // sub-word stores touch only their own lanes
    always_ff @(posedge clk)
    begin
        if (memWrite)
        begin
            case (dataWidth[1:0])
                2'b10:   mem[wordIdx][laneShift +: 8]  <= writeData[7:0];
                2'b01:   mem[wordIdx][laneShift +: 16] <= writeData[15:0];
                default: mem[wordIdx] <= writeData;
            endcase
        end
    end

    assign laneData = mem[wordIdx] >> laneShift; // selected lane in low bits

    always_comb
    begin
        case (dataWidth)
            MEM_BYTE:  readData = {{24{laneData[7]}}, laneData[7:0]};
            MEM_BYTEU: readData = {24'd0, laneData[7:0]};
            MEM_HALF:  readData = {{16{laneData[15]}}, laneData[15:0]};
            MEM_HALFU: readData = {16'd0, laneData[15:0]};
            default:   readData = laneData;
        endcase
    end

endmodule

// ==== verilog/executeStage.sv ====
module executeStage
    import rvCorePkg::*;
#(
    parameter int DMEM_WORDS = 256
)
(
    input  logic            clk,
    input  logic            rstN,
    input  fetchPacketT     fetchPacket,
    output redirectT        redirect,
    output logic            retireValid,
    output logic [XLEN-1:0] retirePc,
    output logic [4:0]      retireRd,
    output logic [XLEN-1:0] retireData
);

    ctrlSignalsT     ctrl;
    logic [XLEN-1:0] instr;
    logic [4:0]      rd;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] rs1Data, rs2Data, aluB, aluResult, memData, pcPlus4, wbData;
    logic            zero;
    logic            writeOk;

    assign instr   = fetchPacket.instr;
    assign rd      = instr[11:7];
    assign pcPlus4 = fetchPacket.pc + 32'd4;
    assign writeOk = fetchPacket.valid & rstN; // no state changes from bubbles

    controlUnit ctrlDec (.instr(instr), .zero(zero), .ctrl(ctrl));

    regFile rf (
        .clk(clk), .readAddr1(instr[19:15]), .readAddr2(instr[24:20]),
        .readData1(rs1Data), .readData2(rs2Data),
        .writeEn(ctrl.regWrite & writeOk), .writeAddr(rd), .writeData(wbData)
    );

    always_comb
    begin
        case (ctrl.immSrc)
            IMM_S:   imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            IMM_B:   imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            IMM_J:   imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
            IMM_U:   imm = {instr[31:12], 12'd0};
            default: imm = {{20{instr[31]}}, instr[31:20]};
        endcase
    end

    assign aluB = ctrl.aluSrc ? imm : rs2Data;

    aluUnit alu (.a(rs1Data), .b(aluB), .aluCtrl(ctrl.aluCtrl), .result(aluResult), .zero(zero));

    dataMemory #(.DMEM_WORDS(DMEM_WORDS)) dmem (
        .clk(clk), .addr(aluResult), .writeData(rs2Data),
        .memWrite(ctrl.memWrite & writeOk), .dataWidth(ctrl.dataWidth), .readData(memData)
    );

    always_comb
    begin
        case (ctrl.resultSrc)
            RES_MEM:     wbData = memData;
            RES_PCPLUS4: wbData = pcPlus4;
            RES_IMM:     wbData = imm;
            default:     wbData = aluResult;
        endcase
    end

    // jalr takes rs1 + imm from the alu, bit 0 dropped
    assign redirect.taken  = ctrl.pcSrc & fetchPacket.valid;
    assign redirect.target = ctrl.jalr ? {aluResult[XLEN-1:1], 1'b0} : fetchPacket.pc + imm;

    assign retireValid = fetchPacket.valid;
    assign retirePc    = fetchPacket.pc;
    assign retireRd    = (ctrl.regWrite && rd != 5'd0) ? rd : 5'd0;
    assign retireData  = wbData;

endmodule

// ==== verilog/rvCore.sv ====
module rvCore
    import rvCorePkg::*;
#(
    parameter logic [XLEN-1:0] RESET_PC   = '0,
    parameter int              DMEM_WORDS = 256
)
(
    input  logic            clk,
    input  logic            rstN,
    output logic [XLEN-1:0] instrAddr,
    input  logic [XLEN-1:0] instr,
    output logic            retireValid,
    output logic [XLEN-1:0] retirePc,
    output logic [4:0]      retireRd,
    output logic [XLEN-1:0] retireData
);

    fetchPacketT fetchPacket; // fetch to execute
    redirectT    redirect; // execute back to fetch

    fetchStage #(.RESET_PC(RESET_PC)) fetch (
        .clk(clk), .rstN(rstN), .instrAddr(instrAddr), .instr(instr),
        .redirect(redirect), .fetchPacket(fetchPacket)
    );

    executeStage #(.DMEM_WORDS(DMEM_WORDS)) execute (
        .clk(clk), .rstN(rstN), .fetchPacket(fetchPacket), .redirect(redirect),
        .retireValid(retireValid), .retirePc(retirePc),
        .retireRd(retireRd), .retireData(retireData)
    );

endmodule

// ==== verification/rvCoreAssert_assert.sv ====
module rvCoreAssert
    import rvCorePkg::*;
(
    input logic        clk,
    input logic        rstN,
    input fetchPacketT fetchPacket,
    input redirectT    redirect,
    input logic        memWriteEn
);
    timeunit 1ns;
    timeprecision 1ps;

    // nothing redirects or writes memory while held in reset
    resetQuiet: assert property (@(posedge clk) !rstN |=> !redirect.taken && !memWriteEn)
        else $error("redirect or memory write active during reset");

    targetAligned: assert property (@(posedge clk) disable iff (!rstN)
        redirect.taken |-> redirect.target[1:0] == 2'b00)
        else $error("redirect target not word aligned");

    flushBubble: assert property (@(posedge clk) disable iff (!rstN)
        redirect.taken |=> !fetchPacket.valid) // word behind a redirect is dropped
        else $error("packet still valid after a taken redirect");

endmodule

bind executeStage rvCoreAssert assertChk (
    .clk(clk), .rstN(rstN), .fetchPacket(fetchPacket), .redirect(redirect),
    .memWriteEn(ctrl.memWrite & writeOk)
);

// ==== verification/rvCoreTb.sv ====
module rvCoreTb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int          CLK_PERIOD = 100;
    localparam int          NUM_RETIRE = 3000;
    localparam logic [31:0] RESET_PC   = 32'd0;

    logic        clk;
    logic        rstN;
    logic [31:0] instrAddr;
    logic [31:0] instr;
    logic        retireValid;
    logic [31:0] retirePc;
    logic [4:0]  retireRd;
    logic [31:0] retireData;

    logic [31:0] imem [256];
    logic [31:0] regs [32];
    logic [7:0]  dmem [64]; // bytes of the data window the program touches
    logic [31:0] modelPc;
    logic [31:0] randState;
    logic        bubbleDue;
    int          retired;
    int          errorCount;

    rvCore #(.RESET_PC(RESET_PC), .DMEM_WORDS(256)) uut (.*);

    function automatic logic [31:0] nextRand();
        randState ^= randState << 13;
        randState ^= randState >> 17;
        randState ^= randState << 5;
        return randState;
    endfunction

    task automatic endWithFailure();
        $display("Test failures found");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic reportMismatch(input string msg);
        errorCount++;
        $display("[FAIL] %0t ns: %s", $time, msg);
        endWithFailure();
    endtask

    // prefix seeds x1..x31 and the data window before the random code
    task automatic buildProgram();
        logic [31:0] r;
        logic [31:0] r2;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [11:0] imm;
        logic [12:0] bimm;
        logic [20:0] jimm;
        for (int i = 0; i < 31; i++)
        begin
            r = nextRand();
            imem[i] = {r[11:0], 5'd0, 3'b000, 5'(i + 1), 7'b0010011}; // addi
        end
        for (int i = 0; i < 16; i++)
        begin
            imm = 12'(i * 4);
            imem[31 + i] = {imm[11:5], 5'(i + 1), 5'd0, 3'b010, imm[4:0], 7'b0100011};
        end
        for (int i = 47; i < 256; i++)
        begin
            r = nextRand();
            r2 = nextRand();
            rd = r[12:8];
            rs1 = (r[17:13] == 5'd0) ? 5'd1 : r[17:13];
            rs2 = r[22:18];
            f3 = r[25:23];
            imm = r2[11:0];
            case (r[3:0])
                4'd0, 4'd1, 4'd2, 4'd3:
                    imem[i] = {1'b0, ((f3 == 3'd0 || f3 == 3'd5) && r[26]), 5'd0,
                               rs2, rs1, f3, rd, 7'b0110011};
                4'd4, 4'd5, 4'd6:
                begin
                    if (f3 == 3'd1)
                        imm[11:5] = 7'h00;
                    else if (f3 == 3'd5)
                        imm[11:5] = r[26] ? 7'h20 : 7'h00;
                    imem[i] = {imm, rs1, f3, rd, 7'b0010011};
                end
                4'd7:
                    imem[i] = {r2[31:12], rd, 7'b0110111}; // lui
                4'd8, 4'd9:
                begin
                    if (f3 == 3'd3 || f3 == 3'd6 || f3 == 3'd7)
                        f3 = 3'd2;
                    imm = {6'd0, r2[5:0] >> f3[1:0] << f3[1:0]}; // size aligned
                    imem[i] = {imm, 5'd0, f3, rd, 7'b0000011};
                end
                4'd10, 4'd11:
                begin
                    f3 = (r[24:23] == 2'd3) ? 3'd2 : {1'b0, r[24:23]};
                    imm = {6'd0, r2[5:0] >> f3[1:0] << f3[1:0]};
                    imem[i] = {imm[11:5], rs2, 5'd0, f3, imm[4:0], 7'b0100011};
                end
                4'd12, 4'd13:
                begin
                    if (f3 == 3'd2 || f3 == 3'd3)
                        f3 = f3 + 3'd4;
                    if (r[27])
                        rs2 = rs1; // equal operands now and then
                    bimm = {8'd0, r2[2:0], 2'b00} + 13'd4;
                    imem[i] = {bimm[12], bimm[10:5], rs2, rs1, f3, bimm[4:1], bimm[11],
                               7'b1100011};
                end
                default:
                begin
                    if (r[3:0] == 4'd15 && r[31:29] == 3'd0)
                    begin
                        imm = {2'd0, r2[7:0], 2'b00}; // absolute target from x0
                        imem[i] = {imm, 5'd0, 3'b000, rd, 7'b1100111};
                    end
                    else
                    begin
                        jimm = {15'd0, r2[3:0], 2'b00} + 21'd4; // forward only
                        imem[i] = {jimm[20], jimm[10:1], jimm[11], jimm[19:12], rd,
                                   7'b1101111};
                    end
                end
            endcase
        end
    endtask

    // executes the word at modelPc and checks the retire trace against it
    task automatic stepModel();
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] immI;
        logic [31:0] res;
        logic [31:0] addr;
        logic [31:0] npc;
        logic [4:0]  rd;
        logic [4:0]  expRd;
        logic [2:0]  f3;
        logic        wr;
        logic        taken;
        int          i;
        w = imem[modelPc[9:2]];
        f3 = w[14:12];
        rd = w[11:7];
        a = regs[w[19:15]];
        b = regs[w[24:20]];
        immI = {{20{w[31]}}, w[31:20]};
        wr = 1'b1;
        taken = 1'b0;
        res = '0;
        npc = modelPc + 32'd4;
        case (w[6:0])
            7'b0110011, 7'b0010011:
            begin
                if (w[5] == 1'b0)
                    b = immI;
                case (f3)
                    3'd0: res = (w[5] && w[30]) ? a - b : a + b;
                    3'd1: res = a << b[4:0];
                    3'd2: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    3'd3: res = (a < b) ? 32'd1 : 32'd0;
                    3'd4: res = a ^ b;
                    3'd5:
                    begin
                        if (w[30])
                            res = $signed(a) >>> b[4:0];
                        else
                            res = a >> b[4:0];
                    end
                    3'd6: res = a | b;
                    default: res = a & b;
                endcase
            end
            7'b0110111: res = {w[31:12], 12'd0};
            7'b0000011:
            begin
                addr = a + immI;
                i = int'(addr[5:0]);
                case (f3)
                    3'd0: res = {{24{dmem[i][7]}}, dmem[i]};
                    3'd4: res = {24'd0, dmem[i]};
                    3'd1: res = {{16{dmem[i+1][7]}}, dmem[i+1], dmem[i]};
                    3'd5: res = {16'd0, dmem[i+1], dmem[i]};
                    default: res = {dmem[i+3], dmem[i+2], dmem[i+1], dmem[i]};
                endcase
            end
            7'b0100011:
            begin
                wr = 1'b0;
                addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
                i = int'(addr[5:0]);
                dmem[i] = b[7:0];
                if (f3 != 3'd0)
                    dmem[i+1] = b[15:8];
                if (f3 == 3'd2)
                begin
                    dmem[i+2] = b[23:16];
                    dmem[i+3] = b[31:24];
                end
            end
            7'b1100011:
            begin
                wr = 1'b0;
                case (f3)
                    3'd0: taken = (a == b);
                    3'd1: taken = (a != b);
                    3'd4: taken = ($signed(a) < $signed(b));
                    3'd5: taken = ($signed(a) >= $signed(b));
                    3'd6: taken = (a < b);
                    default: taken = (a >= b);
                endcase
                if (taken)
                    npc = modelPc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            end
            7'b1101111:
            begin
                res = modelPc + 32'd4; // link
                taken = 1'b1;
                npc = modelPc + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            end
            7'b1100111:
            begin
                res = modelPc + 32'd4;
                taken = 1'b1;
                npc = (a + immI) & ~32'd1;
            end
            default: wr = 1'b0;
        endcase
        expRd = (wr && rd != 5'd0) ? rd : 5'd0;
        assert (retireRd == expRd)
            else reportMismatch($sformatf("pc %h retireRd %0d, expected %0d",
                                          modelPc, retireRd, expRd));
        if (expRd != 5'd0)
        begin
            assert (retireData == res)
                else reportMismatch($sformatf("pc %h x%0d data %h, expected %h",
                                              modelPc, rd, retireData, res));
            regs[rd] = res;
        end
        modelPc = npc;
        bubbleDue = taken;
    endtask

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // instruction memory answers the fetch address just after the edge
    always @(posedge clk)
    begin
        #1;
        instr = imem[instrAddr[9:2]];
    end

    initial
    begin
        #(NUM_RETIRE * 2 * CLK_PERIOD + 50 * CLK_PERIOD);
        $display("Timeout: the core stopped retiring instructions");
        endWithFailure();
    end

    initial
    begin
        randState = 32'd64453;
        rstN = 1'b0;
        instr = '0;
        bubbleDue = 1'b1; // packet is still empty right after reset
        retired = 0;
        errorCount = 0;
        modelPc = RESET_PC;
        foreach (regs[i])
            regs[i] = '0;
        foreach (dmem[i])
            dmem[i] = '0;
        buildProgram();
        repeat (4) @(posedge clk);
        #1 rstN = 1'b1;
        while (retired < NUM_RETIRE)
        begin
            @(posedge clk);
            if (bubbleDue)
            begin
                assert (!retireValid)
                    else reportMismatch($sformatf("pc %h retired where a bubble was due",
                                                  retirePc));
                assert (instrAddr == modelPc)
                    else reportMismatch($sformatf("fetch pc %h in bubble, expected %h",
                                                  instrAddr, modelPc));
                bubbleDue = 1'b0;
            end
            else
            begin
                assert (retireValid) else reportMismatch("unexpected bubble, core stalled");
                if (retired == 0)
                    assert (retirePc == RESET_PC)
                        else reportMismatch($sformatf("first pc %h, expected reset pc",
                                                      retirePc));
                assert (retirePc == modelPc)
                    else reportMismatch($sformatf("retirePc %h, expected %h",
                                                  retirePc, modelPc));
                assert (instrAddr == modelPc + 32'd4)
                    else reportMismatch($sformatf("fetch pc %h, expected %h",
                                                  instrAddr, modelPc + 32'd4));
                stepModel();
                retired++;
            end
        end
        if (errorCount == 0)
        begin
            $display("All tests passed!");
            $finish;
        end
        else
            endWithFailure();
    end

endmodule

// ==== rvCore.f ====
verilog/rvCorePkg.sv
verilog/fetchStage.sv
verilog/controlUnit.sv
verilog/aluUnit.sv
verilog/regFile.sv
verilog/dataMemory.sv
verilog/executeStage.sv
verilog/rvCore.sv
verification/rvCoreAssert_assert.sv
verification/rvCoreTb.sv

// ==== Makefile ====
SIM      = verilator
TOP      = rvCoreTb
FILELIST = rvCore.f
FLAGS    = --binary --timing --assert -j 0
BUILD    = obj_dir
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "All tests passed!" $(LOG)

lint:
	$(SIM) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)
